// ==== Bender.yml ====
package:
  name: cache_ctrl

sources:
  - cache_pkg.sv
  - cache_line_store.sv
  - way_select.sv
  - cache_ctrl_fsm.sv
  - cache_top.sv
  - target: test
    files:
      - tb_cache.sv

// ==== cache_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl_fsm (
  input  wire logic                                          clk,
  input  wire logic                                          rst_n,
  // CPU port
  input  wire logic                                          cpu_req_valid,
  input  wire logic                                          cpu_req_write,
  input  wire cache_pkg::addr_t                              cpu_req_addr,
  input  wire cache_pkg::word_t                              cpu_req_wdata,
  output logic                                               cpu_req_ready,
  output logic                                               cpu_resp_valid,
  output cache_pkg::word_t                                   cpu_resp_rdata,
  // Memory port, one block per transfer
  output logic                                               mem_req_valid,
  output logic                                               mem_req_write,
  output cache_pkg::line_addr_t                              mem_req_addr,
  output cache_pkg::block_t                                  mem_req_wdata,
  input  wire logic                                          mem_ack,
  input  wire cache_pkg::block_t                             mem_rdata,
  // Lookup result from way_select
  input  wire logic                                          hit,
  input  wire cache_pkg::way_mask_t                          hit_way,
  input  wire cache_pkg::way_mask_t                          victim_way,
  input  wire logic                                          victim_dirty,
  input  wire cache_pkg::tag_t                               victim_tag,
  input  wire cache_pkg::age_t     [cache_pkg::num_ways-1:0] next_ages,
  input  wire cache_pkg::block_t   [cache_pkg::num_ways-1:0] rd_blocks,
  // Store controls
  output logic                                               rd_en,
  output cache_pkg::set_idx_t                                rd_set,
  output logic                                               wr_line_en,
  output cache_pkg::way_mask_t                               wr_way,
  output cache_pkg::set_idx_t                                wr_set,
  output cache_pkg::tag_t                                    wr_tag,
  output logic                                               wr_dirty,
  output cache_pkg::block_t                                  wr_block,
  output logic                                               wr_age_en,
  output cache_pkg::age_t          [cache_pkg::num_ways-1:0] wr_ages
);

  cache_pkg::ctrl_state_t state_q, state_d;

  // Accepted request
  logic                req_write_q;
  cache_pkg::addr_t    req_addr_q;
  cache_pkg::word_t    req_wdata_q;
  cache_pkg::block_t   line_buf_q;   // Victim block, later the refill block
  cache_pkg::word_t    resp_word_q;

  cache_pkg::offset_t  req_offset;
  cache_pkg::set_idx_t req_set;
  cache_pkg::tag_t     req_tag;
  cache_pkg::block_t   hit_block, victim_block;
  cache_pkg::block_t   base_block, merged_block;
  logic                accept;

  assign accept     = cpu_req_valid && cpu_req_ready;
  assign req_offset = req_addr_q[cache_pkg::offset_bits-1:0];
  assign req_set    = req_addr_q[cache_pkg::offset_bits +: cache_pkg::set_bits];
  assign req_tag    = req_addr_q[cache_pkg::addr_bits-1 -: cache_pkg::tag_bits];

  // Pick hit and victim blocks out of the registered ways
  always_comb begin
    hit_block    = '0;
    victim_block = '0;
    for (int w = 0; w < cache_pkg::num_ways; w++) begin
      if (hit_way[w])    hit_block    = rd_blocks[w];
      if (victim_way[w]) victim_block = rd_blocks[w];
    end
  end

  // Store is untouched until update, so hit still tells hit from refill here
  assign base_block = hit ? hit_block : line_buf_q;

  always_comb begin
    merged_block = base_block;
    if (req_write_q) begin
      merged_block[req_offset*cache_pkg::word_bits +: cache_pkg::word_bits] = req_wdata_q;
    end
  end

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      cache_pkg::idle:      if (accept) state_d = cache_pkg::read_sets;
      cache_pkg::read_sets: state_d = cache_pkg::compare;  // Ways valid next cycle
      cache_pkg::compare: begin
        if (hit)               state_d = cache_pkg::update;
        else if (victim_dirty) state_d = cache_pkg::writeback;
        else                   state_d = cache_pkg::refill;
      end
      cache_pkg::writeback: if (mem_ack) state_d = cache_pkg::refill;
      cache_pkg::refill:    if (mem_ack) state_d = cache_pkg::update;
      cache_pkg::update:    state_d = cache_pkg::respond;
      cache_pkg::respond:   state_d = cache_pkg::idle;
      default:              state_d = cache_pkg::idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= cache_pkg::idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Request, line buffer and response word
  always_ff @(posedge clk) begin
    if (accept) begin
      req_write_q <= cpu_req_write;
      req_addr_q  <= cpu_req_addr;
      req_wdata_q <= cpu_req_wdata;
    end
    if (state_q == cache_pkg::compare && !hit && victim_dirty) begin
      line_buf_q <= victim_block;  // Held for the whole writeback
    end
    if (state_q == cache_pkg::refill && mem_ack) begin
      line_buf_q <= mem_rdata;
    end
    if (state_q == cache_pkg::update) begin
      // Written word on a write, block word on a read
      resp_word_q <= merged_block[req_offset*cache_pkg::word_bits +: cache_pkg::word_bits];
    end
  end

  // CPU side
  assign cpu_req_ready  = (state_q == cache_pkg::idle);
  assign cpu_resp_valid = (state_q == cache_pkg::respond);  // One-cycle pulse
  assign cpu_resp_rdata = resp_word_q;

  // Memory side, fields stable while waiting for ack
  assign mem_req_valid = (state_q == cache_pkg::writeback) || (state_q == cache_pkg::refill);
  assign mem_req_write = (state_q == cache_pkg::writeback);
  assign mem_req_addr  = mem_req_write ? {victim_tag, req_set} : {req_tag, req_set};
  assign mem_req_wdata = line_buf_q;

  // Store read of the request's set
  assign rd_en  = (state_q == cache_pkg::read_sets);
  assign rd_set = req_set;

  // Line write skipped on a read hit so its dirty bit stays
  assign wr_line_en = (state_q == cache_pkg::update) && (req_write_q || !hit);
  assign wr_way     = hit ? hit_way : victim_way;
  assign wr_set     = req_set;
  assign wr_tag     = req_tag;  // Also the lookup tag
  assign wr_dirty   = req_write_q;  // Set on write, clear on read refill
  assign wr_block   = merged_block;
  assign wr_age_en  = (state_q == cache_pkg::update);  // Every access touches LRU
  assign wr_ages    = next_ages;

endmodule

`default_nettype wire

// ==== cache_line_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_line_store (
  input  wire logic                                          clk,
  input  wire logic                                          rst_n,
  // Read side, all four ways of one set
  input  wire logic                                          rd_en,
  input  wire cache_pkg::set_idx_t                           rd_set,
  // Line write to one way
  input  wire logic                                          wr_line_en,
  input  wire cache_pkg::way_mask_t                          wr_way,
  input  wire cache_pkg::set_idx_t                           wr_set,
  input  wire cache_pkg::tag_t                               wr_tag,
  input  wire logic                                          wr_dirty,
  input  wire cache_pkg::block_t                             wr_block,
  // Age write, whole set at once
  input  wire logic                                          wr_age_en,
  input  wire cache_pkg::age_t   [cache_pkg::num_ways-1:0]   wr_ages,
  // Registered read results
  output cache_pkg::tag_t        [cache_pkg::num_ways-1:0]   rd_tags,
  output logic                   [cache_pkg::num_ways-1:0]   rd_valid,
  output logic                   [cache_pkg::num_ways-1:0]   rd_dirty,
  output cache_pkg::age_t        [cache_pkg::num_ways-1:0]   rd_ages,
  output cache_pkg::block_t      [cache_pkg::num_ways-1:0]   rd_blocks
);

  // Arrays indexed [way][set]
  cache_pkg::tag_t                tag_mem  [cache_pkg::num_ways][cache_pkg::num_sets];
  cache_pkg::block_t              data_mem [cache_pkg::num_ways][cache_pkg::num_sets];
  logic [cache_pkg::num_sets-1:0] valid_q  [cache_pkg::num_ways];  // Bit per set
  logic [cache_pkg::num_sets-1:0] dirty_q  [cache_pkg::num_ways];
  cache_pkg::age_t                age_q    [cache_pkg::num_ways][cache_pkg::num_sets];

  // Line state, cleared by reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < cache_pkg::num_ways; w++) begin
        valid_q[w] <= '0;  // All lines invalid and clean
        dirty_q[w] <= '0;
        for (int s = 0; s < cache_pkg::num_sets; s++) begin
          age_q[w][s] <= cache_pkg::age_t'(w);  // Way w starts at age w
        end
      end
      rd_valid <= '0;
      rd_dirty <= '0;
      rd_ages  <= '0;
    end else begin
      for (int w = 0; w < cache_pkg::num_ways; w++) begin
        if (wr_line_en && wr_way[w]) begin
          valid_q[w][wr_set] <= 1'b1;  // Any line write fills the line
          dirty_q[w][wr_set] <= wr_dirty;
        end
        if (wr_age_en) begin
          age_q[w][wr_set] <= wr_ages[w];
        end
        if (rd_en) begin
          rd_valid[w] <= valid_q[w][rd_set];
          rd_dirty[w] <= dirty_q[w][rd_set];
          rd_ages[w]  <= age_q[w][rd_set];
        end
      end
    end
  end

  // Tag and data arrays
  always_ff @(posedge clk) begin
    for (int w = 0; w < cache_pkg::num_ways; w++) begin
      if (wr_line_en && wr_way[w]) begin
        tag_mem[w][wr_set]  <= wr_tag;
        data_mem[w][wr_set] <= wr_block;
      end
      // No write forwarding, reads and writes never share a cycle
      if (rd_en) begin
        rd_tags[w]   <= tag_mem[w][rd_set];
        rd_blocks[w] <= data_mem[w][rd_set];
      end
    end
  end

endmodule

`default_nettype wire

// ==== cache_pkg.sv ====
`default_nettype none

package cache_pkg;

  // Cache geometry
  localparam int num_ways        = 4;  // Ways per set
  localparam int words_per_block = 4;  // Words per line
  localparam int num_sets        = 8;

  // Field widths derived from the geometry
  localparam int word_bits   = 32;
  localparam int addr_bits   = 32;                           // CPU word address
  localparam int offset_bits = $clog2(words_per_block);      // Word index in block
  localparam int set_bits    = $clog2(num_sets);
  localparam int tag_bits    = addr_bits - set_bits - offset_bits;
  localparam int line_bits   = addr_bits - offset_bits;      // Tag then set
  localparam int block_bits  = word_bits * words_per_block;
  localparam int age_bits    = $clog2(num_ways);

  typedef logic [word_bits-1:0]   word_t;
  typedef logic [addr_bits-1:0]   addr_t;
  typedef logic [offset_bits-1:0] offset_t;
  typedef logic [set_bits-1:0]    set_idx_t;
  typedef logic [tag_bits-1:0]    tag_t;
  typedef logic [line_bits-1:0]   line_addr_t;  // Block address on memory port
  typedef logic [block_bits-1:0]  block_t;      // Word 0 in the low bits
  typedef logic [age_bits-1:0]    age_t;        // 0 is most recently used
  typedef logic [num_ways-1:0]    way_mask_t;   // One-hot way

  // LRU way carries this age, also the old age of a newly filled line
  localparam age_t oldest_age = age_t'(num_ways - 1);

  // Controller states
  typedef enum logic [2:0] {
    idle,       // Waiting for a CPU request
    read_sets,  // Store read of all ways in flight
    compare,    // Tag compare on registered ways
    writeback,  // Dirty victim out to memory
    refill,     // Block fetch from memory
    update,     // Line and age write
    respond     // Response pulse to CPU
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== cache_testdata.txt ====
// wr addr wdata exp_rdata exp_refills exp_wbacks early (all hex)
// early=1 drives the request while the previous one is still in flight
// Read miss, then hits in the same block of set 0
0 00000100 00000000 a5a50100 1 0 0
0 00000102 00000000 a5a50102 0 0 0
1 00000101 deadbeef deadbeef 0 0 0
0 00000101 00000000 deadbeef 0 0 0
// Write miss with merge in set 1, then neighbour and merged word
1 00000244 12345678 12345678 1 0 0
0 00000247 00000000 a5a50247 0 0 0
0 00000244 00000000 12345678 0 0 0
// Five tags in set 3, fills ways 3 2 1 then a hit on tag 10
1 0000020c 11110000 11110000 1 0 0
0 0000022d 00000000 a5a5022d 1 0 0
1 0000024e 33330002 33330002 1 0 0
0 0000020c 00000000 11110000 0 0 0
0 0000026f 00000000 a5a5026f 1 0 0
// Touch tag 11 so dirty tag 12 becomes LRU
0 0000022c 00000000 a5a5022c 0 0 0
// Tag 14 evicts dirty tag 12
0 0000028d 00000000 a5a5028d 1 1 0
// Evicted tag 12 returns from memory, evicts dirty tag 10
0 0000024e 00000000 33330002 1 1 1
// Tag 10 back from memory, replaces clean tag 13
0 0000020c 00000000 11110000 1 0 0
0 0000020f 00000000 a5a5020f 0 0 1
// Second fill in set 0, early write hit during the miss
0 00000300 00000000 a5a50300 1 0 0
1 00000103 cafef00d cafef00d 0 0 1
0 00000100 00000000 a5a50100 0 0 0
0 00000101 00000000 deadbeef 0 0 0
// Top of address space in set 7
0 fffffffe 00000000 5a5afffe 1 0 0
0 00000103 00000000 cafef00d 0 0 1

// ==== cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  // CPU port
  input  wire logic                   cpu_req_valid,
  input  wire logic                   cpu_req_write,
  input  wire cache_pkg::addr_t       cpu_req_addr,
  input  wire cache_pkg::word_t       cpu_req_wdata,
  output wire logic                   cpu_req_ready,
  output wire logic                   cpu_resp_valid,
  output wire cache_pkg::word_t       cpu_resp_rdata,
  // Memory port
  output wire logic                   mem_req_valid,
  output wire logic                   mem_req_write,
  output wire cache_pkg::line_addr_t  mem_req_addr,
  output wire cache_pkg::block_t      mem_req_wdata,
  input  wire logic                   mem_ack,
  input  wire cache_pkg::block_t      mem_rdata
);

  // Store read side
  wire logic                                          rd_en;
  wire cache_pkg::set_idx_t                           rd_set;
  wire cache_pkg::tag_t     [cache_pkg::num_ways-1:0] rd_tags;
  wire logic                [cache_pkg::num_ways-1:0] rd_valid;
  wire logic                [cache_pkg::num_ways-1:0] rd_dirty;
  wire cache_pkg::age_t     [cache_pkg::num_ways-1:0] rd_ages;
  wire cache_pkg::block_t   [cache_pkg::num_ways-1:0] rd_blocks;

  // Store write side
  wire logic                                          wr_line_en;
  wire cache_pkg::way_mask_t                          wr_way;
  wire cache_pkg::set_idx_t                           wr_set;
  wire cache_pkg::tag_t                               req_tag;  // Lookup and write tag
  wire logic                                          wr_dirty;
  wire cache_pkg::block_t                             wr_block;
  wire logic                                          wr_age_en;
  wire cache_pkg::age_t     [cache_pkg::num_ways-1:0] wr_ages;

  // Lookup result
  wire logic                                          hit;
  wire cache_pkg::way_mask_t                          hit_way;
  wire cache_pkg::way_mask_t                          victim_way;
  wire logic                                          victim_dirty;
  wire cache_pkg::tag_t                               victim_tag;
  wire cache_pkg::age_t     [cache_pkg::num_ways-1:0] next_ages;

  cache_line_store i_cache_line_store (
    .clk, .rst_n, .rd_en, .rd_set,
    .wr_line_en, .wr_way, .wr_set, .wr_tag (req_tag), .wr_dirty, .wr_block,
    .wr_age_en, .wr_ages,
    .rd_tags, .rd_valid, .rd_dirty, .rd_ages, .rd_blocks
  );

  way_select i_way_select (
    .req_tag, .tags (rd_tags), .valid (rd_valid), .dirty (rd_dirty), .ages (rd_ages),
    .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag, .next_ages
  );

  cache_ctrl_fsm i_cache_ctrl_fsm (
    .clk, .rst_n,
    .cpu_req_valid, .cpu_req_write, .cpu_req_addr, .cpu_req_wdata,
    .cpu_req_ready, .cpu_resp_valid, .cpu_resp_rdata,
    .mem_req_valid, .mem_req_write, .mem_req_addr, .mem_req_wdata, .mem_ack, .mem_rdata,
    .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag, .next_ages, .rd_blocks,
    .rd_en, .rd_set,
    .wr_line_en, .wr_way, .wr_set, .wr_tag (req_tag), .wr_dirty, .wr_block,
    .wr_age_en, .wr_ages
  );

endmodule

`default_nettype wire

// ==== tb_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache;

  localparam int num_fields = 7;    // Columns per operation in the data file
  localparam int max_ops    = 64;
  localparam int wait_limit = 100;  // Cycles before a wait gives up

  logic                  clk;
  logic                  rst_n;
  logic                  cpu_req_valid;
  logic                  cpu_req_write;
  cache_pkg::addr_t      cpu_req_addr;
  cache_pkg::word_t      cpu_req_wdata;
  wire logic             cpu_req_ready;
  wire logic             cpu_resp_valid;
  wire cache_pkg::word_t cpu_resp_rdata;
  wire logic             mem_req_valid;
  wire logic             mem_req_write;
  wire cache_pkg::line_addr_t mem_req_addr;
  wire cache_pkg::block_t     mem_req_wdata;
  logic                  mem_ack;
  cache_pkg::block_t     mem_rdata;

  cache_pkg::word_t      testdata [num_fields*max_ops];  // Flat, one field per entry
  cache_pkg::word_t      mem_words [cache_pkg::addr_t];  // Sparse backing memory
  logic [31:0]           lfsr_state;
  int                    cycle_cnt = 0;
  int                    mem_reads = 0;   // Refills served
  int                    mem_writes = 0;  // Writebacks served
  int                    error_cnt = 0;
  int                    failed_ops = 0;
  int                    num_ops = 0;
  int                    ack_wait;
  bit                    next_presented;  // Next op already driven early
  bit                    timed_out;
  cache_pkg::line_addr_t pending_addr;    // Memory request fields at first sight
  logic                  pending_write;

  cache_top i_cache_top (
    .clk, .rst_n,
    .cpu_req_valid, .cpu_req_write, .cpu_req_addr, .cpu_req_wdata,
    .cpu_req_ready, .cpu_resp_valid, .cpu_resp_rdata,
    .mem_req_valid, .mem_req_write, .mem_req_addr, .mem_req_wdata,
    .mem_ack, .mem_rdata
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;  // Read on falling edges only

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Ack delay of 1 to 4 cycles from two LFSR bits
  function int draw_ack_delay();
    logic [1:0] bits;
    lfsr_state = lfsr_step(lfsr_state);
    bits[0]    = lfsr_state[0];
    lfsr_state = lfsr_step(lfsr_state);
    bits[1]    = lfsr_state[0];
    return 1 + int'(bits);
  endfunction

  // Unwritten words read back as address XOR a fixed pattern
  function automatic cache_pkg::word_t model_read_word(input cache_pkg::addr_t a);
    if (mem_words.exists(a)) return mem_words[a];
    return a ^ 32'hA5A5_0000;
  endfunction

  // Performs the block transfer of the current memory request
  task automatic serve_memory();
    cache_pkg::addr_t  a;
    cache_pkg::block_t blk;
    blk = '0;
    for (int k = 0; k < cache_pkg::words_per_block; k++) begin
      a = {mem_req_addr, cache_pkg::offset_t'(k)};
      if (mem_req_write) begin
        mem_words[a] = mem_req_wdata[k*cache_pkg::word_bits +: cache_pkg::word_bits];
      end else begin
        blk[k*cache_pkg::word_bits +: cache_pkg::word_bits] = model_read_word(a);
      end
    end
    if (mem_req_write) mem_writes++;
    else begin
      mem_rdata = blk;
      mem_reads++;
    end
  endtask

  // Memory model, ack driven on falling edges
  initial begin
    mem_ack    = 1'b0;
    mem_rdata  = '0;
    ack_wait   = 0;
    lfsr_state = 32'h5b10_b28f;
    forever begin
      @(negedge clk);
      if (mem_ack) begin
        mem_ack = 1'b0;  // One-cycle ack
      end else if (mem_req_valid) begin
        if (ack_wait == 0) begin  // New request
          ack_wait      = draw_ack_delay();
          pending_addr  = mem_req_addr;
          pending_write = mem_req_write;
        end
        ack_wait--;
        if (ack_wait == 0) begin
          assert (mem_req_addr == pending_addr) else begin
            $display("[FAIL] mem_req_addr got %h expected %h", mem_req_addr, pending_addr);
            error_cnt++;
          end
          assert (mem_req_write == pending_write) else begin
            $display("[FAIL] mem_req_write got %h expected %h", mem_req_write, pending_write);
            error_cnt++;
          end
          serve_memory();
          mem_ack = 1'b1;
        end
      end
    end
  end

  task automatic drive_request(input int idx);
    cpu_req_valid = 1'b1;
    cpu_req_write = testdata[idx*num_fields][0];
    cpu_req_addr  = testdata[idx*num_fields + 1];
    cpu_req_wdata = testdata[idx*num_fields + 2];
  endtask

  // Called on a falling edge, returns on the falling edge before acceptance
  task automatic wait_accept(output bit found);
    found = 1'b0;
    for (int n = 0; n < wait_limit; n++) begin
      if (cpu_req_ready) begin
        found = 1'b1;
        break;
      end
      @(negedge clk);
    end
    if (!found) $display("Timeout: cpu_req_ready stayed low for %0d cycles", wait_limit);
  endtask

  task automatic wait_response(output bit found);
    found = 1'b0;
    for (int n = 0; n < wait_limit; n++) begin
      if (cpu_resp_valid) begin
        found = 1'b1;
        break;
      end
      if (cpu_req_valid) begin  // Early request must be held off
        assert (!cpu_req_ready) else begin
          $display("[FAIL] cpu_req_ready got %h expected %h while busy", cpu_req_ready, 1'b0);
          error_cnt++;
        end
      end
      @(negedge clk);
    end
    if (!found) $display("Timeout: no cpu_resp_valid within %0d cycles", wait_limit);
  endtask

  task automatic run_op(input int idx);
    cache_pkg::word_t exp_rdata;
    int               exp_refills;
    int               exp_wbacks;
    int               reads_at_accept;
    int               writes_at_accept;
    int               accept_cycle;
    int               errors_at_start;
    bit               found;
    exp_rdata       = testdata[idx*num_fields + 3];
    exp_refills     = int'(testdata[idx*num_fields + 4]);
    exp_wbacks      = int'(testdata[idx*num_fields + 5]);
    errors_at_start = error_cnt;
    @(negedge clk);
    if (!next_presented) drive_request(idx);
    next_presented = 1'b0;
    wait_accept(found);
    if (!found) begin
      timed_out = 1'b1;
      return;
    end
    @(posedge clk);  // Acceptance edge
    @(negedge clk);
    accept_cycle     = cycle_cnt;
    reads_at_accept  = mem_reads;
    writes_at_accept = mem_writes;
    // Next op may go out while this one is still busy
    if (idx + 1 < num_ops && testdata[(idx+1)*num_fields + 6][0]) begin
      drive_request(idx + 1);
      next_presented = 1'b1;
    end else begin
      cpu_req_valid = 1'b0;
    end
    wait_response(found);
    if (!found) begin
      timed_out = 1'b1;
      return;
    end
    assert (cpu_resp_rdata == exp_rdata) else begin
      $display("[FAIL] cpu_resp_rdata got %h expected %h", cpu_resp_rdata, exp_rdata);
      error_cnt++;
    end
    assert (mem_reads - reads_at_accept == exp_refills) else begin
      $display("[FAIL] mem refill count got %h expected %h",
               mem_reads - reads_at_accept, exp_refills);
      error_cnt++;
    end
    assert (mem_writes - writes_at_accept == exp_wbacks) else begin
      $display("[FAIL] mem writeback count got %h expected %h",
               mem_writes - writes_at_accept, exp_wbacks);
      error_cnt++;
    end
    if (exp_refills == 0 && exp_wbacks == 0) begin  // Hits take exactly three cycles
      assert (cycle_cnt - accept_cycle == 3) else begin
        $display("[FAIL] cpu_resp_valid latency got %h expected %h",
                 cycle_cnt - accept_cycle, 3);
        error_cnt++;
      end
    end
    if (error_cnt != errors_at_start) failed_ops++;
    $display("op %0d %s addr %h: %s", idx, testdata[idx*num_fields][0] ? "write" : "read ",
             testdata[idx*num_fields + 1], (error_cnt == errors_at_start) ? "ok" : "mismatch");
  endtask

  initial begin
    rst_n          = 1'b0;
    cpu_req_valid  = 1'b0;
    cpu_req_write  = 1'b0;
    cpu_req_addr   = '0;
    cpu_req_wdata  = '0;
    next_presented = 1'b0;
    timed_out      = 1'b0;
    foreach (testdata[i]) testdata[i] = '1;  // Unused entries mark the end
    $readmemh("cache_testdata.txt", testdata);
    while (num_ops < max_ops && testdata[num_ops*num_fields] != '1) num_ops++;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (cpu_req_ready) else begin
      $display("[FAIL] cpu_req_ready got %h expected %h after reset", cpu_req_ready, 1'b1);
      error_cnt++;
    end
    assert (!cpu_resp_valid) else begin
      $display("[FAIL] cpu_resp_valid got %h expected %h after reset", cpu_resp_valid, 1'b0);
      error_cnt++;
    end
    assert (!mem_req_valid) else begin
      $display("[FAIL] mem_req_valid got %h expected %h after reset", mem_req_valid, 1'b0);
      error_cnt++;
    end
    if (num_ops == 0) begin
      $display("No operations could be read from the data file");
      error_cnt++;
    end
    for (int i = 0; i < num_ops && !timed_out; i++) run_op(i);
    if (timed_out) failed_ops++;
    $display("ops %0d, failed %0d, errors %0d", num_ops, failed_ops, error_cnt);
    if (error_cnt == 0 && !timed_out) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
cache_pkg.sv
cache_line_store.sv
way_select.sv
cache_ctrl_fsm.sv
cache_top.sv
tb_cache.sv

// ==== way_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module way_select (
  input  wire cache_pkg::tag_t                              req_tag,
  // Registered contents of the addressed set
  input  wire cache_pkg::tag_t   [cache_pkg::num_ways-1:0]  tags,
  input  wire logic              [cache_pkg::num_ways-1:0]  valid,
  input  wire logic              [cache_pkg::num_ways-1:0]  dirty,
  input  wire cache_pkg::age_t   [cache_pkg::num_ways-1:0]  ages,
  // Lookup result
  output logic                                              hit,
  output cache_pkg::way_mask_t                              hit_way,
  output cache_pkg::way_mask_t                              victim_way,
  output logic                                              victim_dirty,
  output cache_pkg::tag_t                                   victim_tag,
  output cache_pkg::age_t        [cache_pkg::num_ways-1:0]  next_ages
);

  cache_pkg::way_mask_t touched;  // Way the access lands in
  cache_pkg::age_t      old_age;  // Its age before the access

  // Tag match on valid ways, at most one can match
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < cache_pkg::num_ways; w++) begin
      hit_way[w] = valid[w] && (tags[w] == req_tag);
    end
  end

  assign hit = |hit_way;

  // LRU victim is the way at the oldest age
  always_comb begin
    victim_way = '0;
    // Downward scan so the lowest way wins, ages stay a permutation anyway
    for (int w = cache_pkg::num_ways - 1; w >= 0; w--) begin
      if (ages[w] == cache_pkg::oldest_age) begin
        victim_way    = '0;
        victim_way[w] = 1'b1;
      end
    end
  end

  // Victim attributes for the writeback decision
  always_comb begin
    victim_dirty = 1'b0;
    victim_tag   = '0;
    for (int w = 0; w < cache_pkg::num_ways; w++) begin
      if (victim_way[w]) begin
        victim_dirty = valid[w] && dirty[w];  // Invalid lines never write back
        victim_tag   = tags[w];
      end
    end
  end

  // Hit way on a hit, else the refilled victim
  assign touched = hit ? hit_way : victim_way;

  always_comb begin
    old_age = cache_pkg::oldest_age;  // New line counts as oldest
    for (int w = 0; w < cache_pkg::num_ways; w++) begin
      if (hit_way[w]) begin
        old_age = ages[w];
      end
    end
  end

  // Touched way goes to zero, younger ways age by one
  always_comb begin
    for (int w = 0; w < cache_pkg::num_ways; w++) begin
      if (touched[w]) begin
        next_ages[w] = '0;
      end else if (ages[w] < old_age) begin
        next_ages[w] = ages[w] + cache_pkg::age_t'(1);
      end else begin
        next_ages[w] = ages[w];  // Older than the touched way, unchanged
      end
    end
  end

endmodule

`default_nettype wire
